/* hw/exec_pkg.sv */
// Op field is five bits wide because the ALU has nineteen ops; misaligned accesses are unsupported
package exec_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OP_W       = 5;
    localparam int DIV_STEPS  = 32;
    localparam int DIV_CNT_W  = $clog2(DIV_STEPS + 1);

    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_DIV = 2'd1,
        UNIT_LSU = 2'd2
    } exec_unit_e;

    typedef enum logic [OP_W-1:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_AND  = 5'd2,
        ALU_OR   = 5'd3,
        ALU_XOR  = 5'd4,
        ALU_SLL  = 5'd5,
        ALU_SRL  = 5'd6,
        ALU_SRA  = 5'd7,
        ALU_SLT  = 5'd8,
        ALU_SLTU = 5'd9,
        ALU_BEQ  = 5'd10,
        ALU_BNE  = 5'd11,
        ALU_BLT  = 5'd12,
        ALU_BGE  = 5'd13,
        ALU_BLTU = 5'd14,
        ALU_BGEU = 5'd15,
        ALU_JAL  = 5'd16,
        ALU_JALR = 5'd17,
        ALU_LUI  = 5'd18     // Passes op_b
    } alu_op_e;

    typedef enum logic [OP_W-1:0] {
        DIV_DIV  = 5'd0,
        DIV_DIVU = 5'd1,
        DIV_REM  = 5'd2,
        DIV_REMU = 5'd3
    } div_op_e;

    typedef enum logic [OP_W-1:0] {
        MEM_LB  = 5'd0,
        MEM_LH  = 5'd1,
        MEM_LW  = 5'd2,
        MEM_LBU = 5'd3,
        MEM_LHU = 5'd4,
        MEM_SB  = 5'd5,
        MEM_SH  = 5'd6,
        MEM_SW  = 5'd7
    } mem_op_e;

    // Same bits, read by whichever unit the micro-op targets
    typedef union packed {
        alu_op_e alu;
        div_op_e div;
        mem_op_e mem;
    } exec_op_u;

    typedef struct packed {
        exec_unit_e unit;
        exec_op_u   op;
        logic       rd_write;
    } uop_t;

    typedef struct packed {
        uop_t                  uop;
        logic [XLEN-1:0]       op_a;
        logic [XLEN-1:0]       op_b;     // Immediate already selected
        logic [XLEN-1:0]       rs2_val;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd_addr;
    } issue_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  rd_write;
        logic [XLEN-1:0]       value;
    } wb_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } branch_t;

    function automatic logic is_store(mem_op_e op);
        return op inside {MEM_SB, MEM_SH, MEM_SW};
    endfunction

endpackage

/* hw/int_alu.sv */
// Purely combinational; branch compare uses op_a against rs2_val, taken only while start_i is high
`timescale 1ns/100ps

module int_alu (
    input  logic                      start_i,
    input  exec_pkg::uop_t            uop_i,
    input  logic [exec_pkg::XLEN-1:0] op_a_i,
    input  logic [exec_pkg::XLEN-1:0] op_b_i,
    input  logic [exec_pkg::XLEN-1:0] rs2_val_i,
    input  logic [exec_pkg::XLEN-1:0] pc_i,
    output logic [exec_pkg::XLEN-1:0] result_o,
    output exec_pkg::branch_t         branch_o
);
    import exec_pkg::*;

    alu_op_e         op;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] target_base;
    logic [XLEN-1:0] target_sum;
    logic            eq;
    logic            lt;
    logic            ltu;
    logic            cond;

    assign op       = uop_i.op.alu;
    assign pc_plus4 = pc_i + XLEN'(4);

    // Branch relations against rs2, not the immediate
    assign eq  = (op_a_i == rs2_val_i);
    assign lt  = ($signed(op_a_i) < $signed(rs2_val_i));
    assign ltu = (op_a_i < rs2_val_i);

    always_comb begin
        case (op)
            ALU_ADD:  result_o = op_a_i + op_b_i;
            ALU_SUB:  result_o = op_a_i - op_b_i;
            ALU_AND:  result_o = op_a_i & op_b_i;
            ALU_OR:   result_o = op_a_i | op_b_i;
            ALU_XOR:  result_o = op_a_i ^ op_b_i;
            ALU_SLL:  result_o = op_a_i << op_b_i[4:0];
            ALU_SRL:  result_o = op_a_i >> op_b_i[4:0];
            ALU_SRA:  result_o = $signed(op_a_i) >>> op_b_i[4:0];
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, ($signed(op_a_i) < $signed(op_b_i))};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, (op_a_i < op_b_i)};
            ALU_LUI:  result_o = op_b_i;
            default:  result_o = pc_plus4;      // Link value for jumps
        endcase
    end

    always_comb begin
        case (op)
            ALU_BEQ:  cond = eq;
            ALU_BNE:  cond = !eq;
            ALU_BLT:  cond = lt;
            ALU_BGE:  cond = !lt;
            ALU_BLTU: cond = ltu;
            ALU_BGEU: cond = !ltu;
            ALU_JAL,
            ALU_JALR: cond = 1'b1;
            default:  cond = 1'b0;
        endcase
    end

    // JALR jumps relative to rs1, everything else relative to pc
    assign target_base = (op == ALU_JALR) ? op_a_i : pc_i;
    assign target_sum  = target_base + op_b_i;

    assign branch_o.taken  = start_i & cond;
    assign branch_o.target = {target_sum[XLEN-1:1], 1'b0};

endmodule

/* hw/serial_divider.sv */
// One bit per cycle, DIV_STEPS cycles; start_i must not arrive while a division is running
`timescale 1ns/100ps

module serial_divider (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      start_i,
    input  exec_pkg::div_op_e         op_i,
    input  logic [exec_pkg::XLEN-1:0] dividend_i,
    input  logic [exec_pkg::XLEN-1:0] divisor_i,
    output logic                      done_o,
    output logic [exec_pkg::XLEN-1:0] result_o
);
    import exec_pkg::*;

    logic                 is_signed;
    logic                 neg_a;
    logic                 neg_b;
    logic [XLEN-1:0]      mag_a;
    logic [XLEN-1:0]      mag_b;
    logic                 busy_q;
    logic [DIV_CNT_W-1:0] cnt_q;
    logic [XLEN-1:0]      quot_q;
    logic [XLEN-1:0]      rem_q;
    logic [XLEN-1:0]      divisor_q;
    logic                 neg_quot_q;
    logic                 neg_rem_q;
    logic                 want_rem_q;
    logic [XLEN:0]        shifted;
    logic [XLEN:0]        diff;
    logic [XLEN-1:0]      quot_next;
    logic [XLEN-1:0]      rem_next;
    logic [XLEN-1:0]      quot_fix;
    logic [XLEN-1:0]      rem_fix;

    assign is_signed = (op_i == DIV_DIV) || (op_i == DIV_REM);
    assign neg_a     = is_signed & dividend_i[XLEN-1];
    assign neg_b     = is_signed & divisor_i[XLEN-1];
    assign mag_a     = neg_a ? -dividend_i : dividend_i;
    assign mag_b     = neg_b ? -divisor_i : divisor_i;

    // Restoring step shifts in the next dividend bit and subtracts if it fits
    assign shifted   = {rem_q, quot_q[XLEN-1]};
    assign diff      = shifted - {1'b0, divisor_q};
    assign rem_next  = diff[XLEN] ? shifted[XLEN-1:0] : diff[XLEN-1:0];
    assign quot_next = {quot_q[XLEN-2:0], !diff[XLEN]};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start_i) begin
            busy_q <= 1'b1;
            cnt_q  <= DIV_CNT_W'(DIV_STEPS);
        end else if (done_o) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            cnt_q <= cnt_q - DIV_CNT_W'(1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            quot_q     <= mag_a;
            rem_q      <= '0;
            divisor_q  <= mag_b;
            // Zero divisor keeps the all-ones quotient unsigned-looking
            neg_quot_q <= (neg_a ^ neg_b) & (divisor_i != '0);
            neg_rem_q  <= neg_a;
            want_rem_q <= (op_i == DIV_REM) || (op_i == DIV_REMU);
        end else if (busy_q) begin
            rem_q  <= rem_next;
            quot_q <= quot_next;
        end
    end

    // Most negative over minus one falls out as the dividend with zero remainder
    assign quot_fix = neg_quot_q ? -quot_next : quot_next;   // Last bit from the step in flight
    assign rem_fix  = neg_rem_q ? -rem_next : rem_next;

    assign done_o   = busy_q & (cnt_q == DIV_CNT_W'(1));
    assign result_o = want_rem_q ? rem_fix : quot_fix;

endmodule

/* hw/load_store_unit.sv */
// Request goes out in the start cycle and is held under stall; misaligned accesses give undefined data
`timescale 1ns/100ps

module load_store_unit (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      start_i,
    input  exec_pkg::mem_op_e         op_i,
    input  logic [exec_pkg::XLEN-1:0] addr_i,
    input  logic [exec_pkg::XLEN-1:0] store_data_i,
    output logic                      done_o,
    output logic [exec_pkg::XLEN-1:0] result_o,
    output logic                      mem_req_o,
    output logic                      mem_we_o,
    output logic [exec_pkg::XLEN-1:0] mem_addr_o,
    output logic [exec_pkg::XLEN-1:0] mem_wdata_o,
    output logic [3:0]                mem_be_o,
    input  logic [exec_pkg::XLEN-1:0] mem_rdata_i,
    input  logic                      mem_stall_i
);
    import exec_pkg::*;

    typedef struct packed {
        mem_op_e         op;
        logic [1:0]      offs;    // Byte offset within the word
        logic [XLEN-1:0] addr;    // Word aligned
        logic [XLEN-1:0] wdata;
        logic [3:0]      be;
    } access_t;

    access_t         new_acc;
    access_t         acc_q;
    access_t         acc;
    logic            pend_q;
    logic [XLEN-1:0] lane;

    always_comb begin
        new_acc.op   = op_i;
        new_acc.offs = addr_i[1:0];
        new_acc.addr = {addr_i[XLEN-1:2], 2'b00};
        case (op_i)
            MEM_LB, MEM_LBU, MEM_SB: begin
                new_acc.wdata = {4{store_data_i[7:0]}};
                new_acc.be    = 4'b0001 << addr_i[1:0];
            end
            MEM_LH, MEM_LHU, MEM_SH: begin
                new_acc.wdata = {2{store_data_i[15:0]}};
                new_acc.be    = 4'b0011 << {addr_i[1], 1'b0};
            end
            default: begin
                new_acc.wdata = store_data_i;
                new_acc.be    = 4'b1111;
            end
        endcase
    end

    // Pending only when the first try was stalled
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pend_q <= 1'b0;
        end else if (start_i) begin
            pend_q <= mem_stall_i;
        end else if (!mem_stall_i) begin
            pend_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            acc_q <= new_acc;
        end
    end

    assign acc = pend_q ? acc_q : new_acc;

    assign mem_req_o   = start_i | pend_q;
    assign mem_we_o    = mem_req_o & is_store(acc.op);
    assign mem_addr_o  = acc.addr;
    assign mem_wdata_o = acc.wdata;
    assign mem_be_o    = acc.be;

    assign done_o = mem_req_o & !mem_stall_i;
    assign lane   = mem_rdata_i >> {acc.offs, 3'b000};   // Addressed byte to the bottom

    always_comb begin
        case (acc.op)
            MEM_LB:  result_o = {{(XLEN-8){lane[7]}}, lane[7:0]};
            MEM_LBU: result_o = {{(XLEN-8){1'b0}}, lane[7:0]};
            MEM_LH:  result_o = {{(XLEN-16){lane[15]}}, lane[15:0]};
            MEM_LHU: result_o = {{(XLEN-16){1'b0}}, lane[15:0]};
            MEM_LW:  result_o = mem_rdata_i;
            default: result_o = '0;                  // Stores return nothing
        endcase
    end

endmodule

/* hw/exec_result_stage.sv */
// Single micro-op in flight; ready drops only while the divider or a stalled access is busy
`timescale 1ns/100ps

module exec_result_stage (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            issue_valid_i,
    input  exec_pkg::uop_t                  uop_i,
    input  logic [exec_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  logic [exec_pkg::XLEN-1:0]       alu_result_i,
    input  exec_pkg::branch_t               alu_branch_i,
    input  logic                            div_done_i,
    input  logic [exec_pkg::XLEN-1:0]       div_result_i,
    input  logic                            lsu_done_i,
    input  logic [exec_pkg::XLEN-1:0]       lsu_result_i,
    output logic                            issue_ready_o,
    output logic                            alu_start_o,
    output logic                            div_start_o,
    output logic                            lsu_start_o,
    output logic                            wb_valid_o,
    output exec_pkg::wb_t                   wb_o,
    output exec_pkg::branch_t               branch_o
);
    import exec_pkg::*;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  rd_write;
    } dest_t;

    logic            busy_q;
    logic            accept;
    logic            no_write;
    logic            done;
    logic [XLEN-1:0] value;
    dest_t           new_dest;
    dest_t           dest_q;
    dest_t           dest;

    assign issue_ready_o = !busy_q;
    assign accept        = issue_valid_i & issue_ready_o;
    assign alu_start_o   = accept & (uop_i.unit == UNIT_ALU);
    assign div_start_o   = accept & (uop_i.unit == UNIT_DIV);
    assign lsu_start_o   = accept & (uop_i.unit == UNIT_LSU);

    // Stores and conditional branches never write rd
    always_comb begin
        case (uop_i.unit)
            UNIT_ALU: no_write = uop_i.op.alu inside {ALU_BEQ, ALU_BNE, ALU_BLT,
                                                      ALU_BGE, ALU_BLTU, ALU_BGEU};
            UNIT_LSU: no_write = is_store(uop_i.op.mem);
            default:  no_write = 1'b0;
        endcase
    end

    assign new_dest.rd_addr  = rd_addr_i;
    assign new_dest.rd_write = uop_i.rd_write & !no_write;
    assign dest              = accept ? new_dest : dest_q;   // Same-cycle finish uses live fields

    assign done  = alu_start_o | div_done_i | lsu_done_i;
    assign value = alu_start_o ? alu_result_i :
                   div_done_i  ? div_result_i : lsu_result_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q     <= 1'b0;
            wb_valid_o <= 1'b0;
            branch_o   <= '0;
        end else begin
            if (accept) begin
                busy_q <= div_start_o | (lsu_start_o & !lsu_done_i);
            end else if (div_done_i | lsu_done_i) begin
                busy_q <= 1'b0;
            end
            wb_valid_o <= done;
            branch_o   <= alu_branch_i;       // Taken already gated by ALU start
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            dest_q <= new_dest;
        end
        if (done) begin
            wb_o.rd_addr  <= dest.rd_addr;
            wb_o.rd_write <= dest.rd_write;
            wb_o.value    <= value;
        end
    end

endmodule

/* hw/exec_stage.sv */
// Execute stage top; decode must hold issue_i stable while valid is high and ready is low
`timescale 1ns/100ps

module exec_stage (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      issue_valid_i,
    input  exec_pkg::issue_t          issue_i,
    output logic                      issue_ready_o,
    output logic                      wb_valid_o,
    output exec_pkg::wb_t             wb_o,
    output exec_pkg::branch_t         branch_o,
    output logic                      mem_req_o,
    output logic                      mem_we_o,
    output logic [exec_pkg::XLEN-1:0] mem_addr_o,
    output logic [exec_pkg::XLEN-1:0] mem_wdata_o,
    output logic [3:0]                mem_be_o,
    input  logic [exec_pkg::XLEN-1:0] mem_rdata_i,
    input  logic                      mem_stall_i
);
    import exec_pkg::*;

    uop_t            alu_uop;
    branch_t         alu_branch;
    logic            alu_start;
    logic            div_start;
    logic            lsu_start;
    logic            div_done;
    logic            lsu_done;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] div_result;
    logic [XLEN-1:0] lsu_result;

    // Memory ops borrow the ALU adder for the address
    always_comb begin
        alu_uop = issue_i.uop;
        if (issue_i.uop.unit == UNIT_LSU) begin
            alu_uop.op.alu = ALU_ADD;
        end
    end

    int_alu int_alu_i (
        .start_i   (alu_start),
        .uop_i     (alu_uop),
        .op_a_i    (issue_i.op_a),
        .op_b_i    (issue_i.op_b),
        .rs2_val_i (issue_i.rs2_val),
        .pc_i      (issue_i.pc),
        .result_o  (alu_result),
        .branch_o  (alu_branch)
    );

    serial_divider serial_divider_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .start_i    (div_start),
        .op_i       (issue_i.uop.op.div),
        .dividend_i (issue_i.op_a),
        .divisor_i  (issue_i.op_b),
        .done_o     (div_done),
        .result_o   (div_result)
    );

    load_store_unit load_store_unit_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .start_i      (lsu_start),
        .op_i         (issue_i.uop.op.mem),
        .addr_i       (alu_result),
        .store_data_i (issue_i.rs2_val),
        .done_o       (lsu_done),
        .result_o     (lsu_result),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_be_o     (mem_be_o),
        .mem_rdata_i  (mem_rdata_i),
        .mem_stall_i  (mem_stall_i)
    );

    exec_result_stage exec_result_stage_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .issue_valid_i (issue_valid_i),
        .uop_i         (issue_i.uop),
        .rd_addr_i     (issue_i.rd_addr),
        .alu_result_i  (alu_result),
        .alu_branch_i  (alu_branch),
        .div_done_i    (div_done),
        .div_result_i  (div_result),
        .lsu_done_i    (lsu_done),
        .lsu_result_i  (lsu_result),
        .issue_ready_o (issue_ready_o),
        .alu_start_o   (alu_start),
        .div_start_o   (div_start),
        .lsu_start_o   (lsu_start),
        .wb_valid_o    (wb_valid_o),
        .wb_o          (wb_o),
        .branch_o      (branch_o)
    );

endmodule

/* verification/exec_stage_tb.sv */
// Run from the project root so the pattern path resolves; the memory model spans 256 bytes only
`timescale 1ns/100ps

module exec_stage_tb;
    import exec_pkg::*;

    localparam int CLK_HALF  = 4;
    localparam int MAX_WAIT  = 100;
    localparam int MEM_WORDS = 64;
    localparam int NAME_W    = 8 * 24;
    localparam int DIV_LAT   = DIV_STEPS + 1;   // Divider writeback latency after acceptance

    logic            clk_i;
    logic            rst_i;
    logic            issue_valid_i;
    issue_t          issue_i;
    logic            issue_ready_o;
    logic            wb_valid_o;
    wb_t             wb_o;
    branch_t         branch_o;
    logic            mem_req_o;
    logic            mem_we_o;
    logic [XLEN-1:0] mem_addr_o;
    logic [XLEN-1:0] mem_wdata_o;
    logic [3:0]      mem_be_o;
    logic [XLEN-1:0] mem_rdata_i;
    logic            mem_stall_i;

    logic [XLEN-1:0] mem_model [MEM_WORDS];
    integer          seed;
    int              stall_left;
    int              errors;
    int              tests;
    int              failed_tests;

    // Fields of the current pattern line
    logic [NAME_W-1:0] t_name;
    int                t_unit;
    int                t_op;
    int                t_rd;
    int                t_wr;
    int                t_tk;
    logic [XLEN-1:0]   t_a;
    logic [XLEN-1:0]   t_b;
    logic [XLEN-1:0]   t_rs2;
    logic [XLEN-1:0]   t_pc;
    logic [XLEN-1:0]   t_val;              // Store lane data for stores
    logic [3:0]        t_be;
    logic [XLEN-1:0]   t_tgt;

    exec_stage exec_stage_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .issue_ready_o (issue_ready_o),
        .wb_valid_o    (wb_valid_o),
        .wb_o          (wb_o),
        .branch_o      (branch_o),
        .mem_req_o     (mem_req_o),
        .mem_we_o      (mem_we_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_be_o      (mem_be_o),
        .mem_rdata_i   (mem_rdata_i),
        .mem_stall_i   (mem_stall_i)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #CLK_HALF clk_i = ~clk_i;
        end
    end

    task automatic report_mismatch(string what, logic [31:0] exp, logic [31:0] act);
        $display("Mismatch %0s %0s: expected 0x%h, actual 0x%h", t_name, what, exp, act);
        errors++;
    endtask

    task automatic report_failure(string msg);
        $display("Error in %0s: %0s", t_name, msg);
        errors++;
    endtask

    task automatic finish_test(int err_start);
        tests++;
        if (errors == err_start) begin
            $display("pass %0s", t_name);
        end else begin
            $display("fail %0s", t_name);
            failed_tests++;
        end
    endtask

    // Known words, every one different
    task automatic fill_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[i] = 32'hC3A5_0000 + i * 32'h0000_0101;
        end
    endtask

    task automatic skip_comment(int fd);
        int ch;
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
        end
    endtask

    task automatic run_test();
        int              err_start;
        int              cyc;
        int              acc_cyc;
        int              lat;
        int              exp_lat;
        int              n_stall;
        int              wb_cnt;
        int              mem_cnt;
        logic            accepted;
        logic            held;
        logic            is_store_op;
        logic [XLEN-1:0] addr;
        logic [5:0]      idx;
        logic [XLEN-1:0] hold_addr;
        logic [XLEN-1:0] hold_wdata;
        logic [3:0]      hold_be;
        logic            hold_we;

        err_start   = errors;
        addr        = (t_a + t_b) & ~32'h3;
        idx         = addr[7:2];
        is_store_op = (t_unit == 2) && (t_op >= 5);
        @(negedge clk_i);
        issue_valid_i        = 1'b1;
        issue_i.uop.unit     = exec_unit_e'(t_unit[1:0]);
        issue_i.uop.op.alu   = alu_op_e'(t_op[4:0]);
        issue_i.uop.rd_write = 1'b1;
        issue_i.op_a         = t_a;
        issue_i.op_b         = t_b;
        issue_i.rs2_val      = t_rs2;
        issue_i.pc           = t_pc;
        issue_i.rd_addr      = t_rd[4:0];
        stall_left           = 0;
        if (t_unit == 2) begin
            stall_left  = {$random(seed)} % 4;
            mem_rdata_i = mem_model[idx];
        end
        mem_stall_i = (stall_left != 0);
        n_stall     = stall_left;
        exp_lat     = (t_unit == 1) ? DIV_LAT : 1 + n_stall;
        accepted    = 1'b0;
        held        = 1'b0;
        wb_cnt      = 0;
        mem_cnt     = 0;
        cyc         = 0;
        acc_cyc     = 0;
        while (wb_cnt == 0 && cyc < MAX_WAIT) begin
            @(posedge clk_i);
            cyc++;
            if (accepted && wb_valid_o) begin
                wb_cnt++;
                lat = cyc - acc_cyc;
                if (lat != exp_lat) report_mismatch("latency", exp_lat, lat);
                if (wb_o.rd_write !== t_wr[0]) begin
                    report_mismatch("rd_write", t_wr, 32'(wb_o.rd_write));
                end
                if (t_wr != 0 && wb_o.rd_addr !== t_rd[4:0]) begin
                    report_mismatch("rd_addr", t_rd, 32'(wb_o.rd_addr));
                end
                if (t_wr != 0 && wb_o.value !== t_val) begin
                    report_mismatch("value", t_val, wb_o.value);
                end
                if (branch_o.taken !== t_tk[0]) begin
                    report_mismatch("taken", t_tk, 32'(branch_o.taken));
                end
                if (t_tk != 0 && branch_o.target !== t_tgt) begin
                    report_mismatch("target", t_tgt, branch_o.target);
                end
            end else if (accepted) begin
                if (issue_ready_o) report_failure("issue ready high while the unit is busy");
                if (branch_o.taken) report_failure("branch taken before the writeback cycle");
            end
            // Memory model
            if (held) begin
                if (!mem_req_o || mem_addr_o !== hold_addr || mem_we_o !== hold_we
                    || mem_be_o !== hold_be || mem_wdata_o !== hold_wdata) begin
                    report_failure("memory request changed while stalled");
                end
            end
            held = 1'b0;
            if (mem_req_o && mem_stall_i) begin
                held       = 1'b1;
                hold_addr  = mem_addr_o;
                hold_we    = mem_we_o;
                hold_be    = mem_be_o;
                hold_wdata = mem_wdata_o;
            end else if (mem_req_o) begin
                mem_cnt++;
                if (mem_addr_o !== addr) report_mismatch("address", addr, mem_addr_o);
                if (mem_we_o !== is_store_op) report_failure("wrong memory write enable");
                if (is_store_op && mem_be_o !== t_be) report_mismatch("byte enable", 32'(t_be),
                                                                      32'(mem_be_o));
                if (is_store_op && mem_wdata_o !== t_val) report_mismatch("store data", t_val,
                                                                          mem_wdata_o);
                if (mem_we_o) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_be_o[b]) begin
                            mem_model[mem_addr_o[7:2]][8*b +: 8] = mem_wdata_o[8*b +: 8];
                        end
                    end
                end
            end
            if (!accepted && issue_ready_o) begin
                accepted = 1'b1;
                acc_cyc  = cyc;
            end
            if (wb_cnt == 0) begin
                @(negedge clk_i);
                if (accepted) issue_valid_i = 1'b0;
                if (stall_left > 0) stall_left--;
                mem_stall_i = (stall_left != 0);
            end
        end
        @(negedge clk_i);
        issue_valid_i = 1'b0;
        mem_stall_i   = 1'b0;
        if (wb_cnt == 0) begin
            report_failure("timed out waiting for the writeback");
        end else begin
            @(posedge clk_i);
            if (wb_valid_o) report_failure("second writeback for one micro-op");
            if (branch_o.taken) report_failure("branch taken held for more than one cycle");
            if (mem_cnt != ((t_unit == 2) ? 1 : 0)) begin
                report_failure("wrong number of memory accesses");
            end
        end
        finish_test(err_start);
    endtask

    initial begin
        int fd;
        int code;
        int err_start;
        logic reading;

        seed          = 5;
        errors        = 0;
        tests         = 0;
        failed_tests  = 0;
        stall_left    = 0;
        rst_i         = 1'b1;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        mem_rdata_i   = '0;
        mem_stall_i   = 1'b0;
        fill_memory();
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        t_name    = NAME_W'("reset_state");
        err_start = errors;
        @(posedge clk_i);
        if (wb_valid_o !== 1'b0) report_failure("writeback valid after reset");
        if (branch_o.taken !== 1'b0) report_failure("branch taken after reset");
        if (mem_req_o !== 1'b0) report_failure("memory request after reset");
        if (issue_ready_o !== 1'b1) report_failure("issue ready low after reset");
        finish_test(err_start);

        fd = $fopen("verification/exec_stage_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file");
            errors++;
        end else begin
            reading = 1'b1;
            while (reading) begin
                t_name = '0;
                code   = $fscanf(fd, "%s", t_name);
                if (code != 1) begin
                    reading = 1'b0;
                end else if (t_name == NAME_W'("#")) begin
                    skip_comment(fd);
                end else begin
                    code = $fscanf(fd, "%d %d %h %h %h %h %d %d %h %h %d %h", t_unit, t_op,
                                   t_a, t_b, t_rs2, t_pc, t_rd, t_wr, t_val, t_be, t_tk, t_tgt);
                    if (code != 12) begin
                        report_failure("pattern line is malformed");
                        reading = 1'b0;
                    end else begin
                        run_test();
                    end
                end
            end
            $fclose(fd);
        end

        $display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0 && tests > 1) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verification/exec_stage_patterns.txt */
# name unit op op_a op_b rs2 pc rd wr value be taken target (unit 0 ALU, 1 DIV, 2 LSU)
# unit op rd wr taken in decimal, the rest in hex; value is the lane data for stores
alu_add      0  0 00000005 00000007 00000000 00000000  1 1 0000000c 0 0 00000000
alu_sub      0  1 00000005 00000007 00000000 00000000  2 1 fffffffe 0 0 00000000
alu_and      0  2 f0f0f0f0 0ff00ff0 00000000 00000000  3 1 00f000f0 0 0 00000000
alu_xor      0  4 f0f0f0f0 0ff00ff0 00000000 00000000  4 1 ff00ff00 0 0 00000000
alu_sll      0  5 00000003 00000024 00000000 00000000  5 1 00000030 0 0 00000000
alu_srl      0  6 80000000 0000001f 00000000 00000000  6 1 00000001 0 0 00000000
alu_sra      0  7 80000000 00000004 00000000 00000000  7 1 f8000000 0 0 00000000
alu_slt      0  8 ffffffff 00000001 00000000 00000000  8 1 00000001 0 0 00000000
alu_sltu     0  9 ffffffff 00000001 00000000 00000000  9 1 00000000 0 0 00000000
alu_lui      0 18 00000000 12345000 00000000 00000000 10 1 12345000 0 0 00000000
beq_taken    0 10 00000011 00000040 00000011 00001000 11 0 00000000 0 1 00001040
bne_not      0 11 00000011 00000040 00000011 00001000 12 0 00000000 0 0 00000000
blt_taken    0 12 fffffff0 00000020 00000001 00001000 13 0 00000000 0 1 00001020
bge_taken    0 13 00000005 fffffff8 00000005 00001000 14 0 00000000 0 1 00000ff8
bltu_not     0 14 fffffff0 00000020 00000001 00001000 15 0 00000000 0 0 00000000
bgeu_taken   0 15 fffffff0 00000010 00000001 00001000 16 0 00000000 0 1 00001010
jal          0 16 00000000 00000100 00000000 00001000 17 1 00001004 0 1 00001100
jalr         0 17 00002003 00000004 00000000 00001000 18 1 00001004 0 1 00002006
div_signed   1  0 fffffff9 00000002 00000000 00000000 19 1 fffffffd 0 0 00000000
rem_signed   1  2 fffffff9 00000002 00000000 00000000 20 1 ffffffff 0 0 00000000
divu         1  1 00000064 00000007 00000000 00000000 21 1 0000000e 0 0 00000000
remu         1  3 00000064 00000007 00000000 00000000 22 1 00000002 0 0 00000000
div_by_zero  1  0 0000002a 00000000 00000000 00000000 23 1 ffffffff 0 0 00000000
rem_by_zero  1  2 0000002a 00000000 00000000 00000000 24 1 0000002a 0 0 00000000
div_overflow 1  0 80000000 ffffffff 00000000 00000000 25 1 80000000 0 0 00000000
rem_overflow 1  2 80000000 ffffffff 00000000 00000000 26 1 00000000 0 0 00000000
lw_fill      2  2 00000010 00000004 00000000 00000000 27 1 c3a50505 0 0 00000000
lb_fill      2  0 00000010 00000007 00000000 00000000 28 1 ffffffc3 0 0 00000000
lhu_fill     2  4 00000010 00000006 00000000 00000000 29 1 0000c3a5 0 0 00000000
sw_word      2  7 00000020 00000000 89abcdef 00000000 30 0 89abcdef f 0 00000000
sb_byte      2  5 00000020 00000001 0000005a 00000000 31 0 5a5a5a5a 2 0 00000000
sh_half      2  6 00000020 00000002 00008001 00000000  1 0 80018001 c 0 00000000
lw_after     2  2 00000020 00000000 00000000 00000000  2 1 80015aef 0 0 00000000
lh_after     2  1 00000020 00000002 00000000 00000000  3 1 ffff8001 0 0 00000000
lbu_after    2  3 00000020 00000003 00000000 00000000  4 1 00000080 0 0 00000000
lb_after     2  0 00000020 00000001 00000000 00000000  5 1 0000005a 0 0 00000000

/* flist.f */
hw/exec_pkg.sv
hw/int_alu.sv
hw/serial_divider.sv
hw/load_store_unit.sv
hw/exec_result_stage.sv
hw/exec_stage.sv
verification/exec_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the execute stage testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/100ps -f flist.f --top-module exec_stage_tb \
    && ./obj_dir/Vexec_stage_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TEST OK" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
